// ==== dv/exec_checker.sv ====
// Scoreboard for the execute subsystem, own eight-register model
// Instructions are applied to the model in issue order, on the ack rise
// Test name changes only once all results of the last test are in
`timescale 1ns/100ps
`default_nettype none

module exec_checker
  import simple_exec_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic [INSTR_W-1:0]    instr_i,
  input  wire logic                  instr_ack_i,
  input  wire logic                  result_req_i,
  input  wire logic [REG_ADDR_W-1:0] result_rd_i,
  input  wire logic [DATA_WIDTH-1:0] result_data_i,
  output int unsigned                pass_o,
  output int unsigned                fail_o
);

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [DATA_WIDTH-1:0] data;
  } expect_t;

  logic [DATA_WIDTH-1:0] model_regs [8];
  expect_t               exp_q [$];    // Oldest expected result first
  logic                  ack_seen;     // Last sampled levels, for edge detection
  logic                  req_seen;
  string                 test_name = "none";
  int unsigned           test_results;
  int unsigned           test_errors;

  //////////////////////////////
  // Reference rules
  //////////////////////////////
  function automatic logic [DATA_WIDTH-1:0] model_result(input logic [3:0] code,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
      input logic [IMM_W-1:0] imm);
    logic [DATA_WIDTH-1:0] sext;
    sext = DATA_WIDTH'($signed(imm));              // Sign-extended immediate
    case (code)
      ADD     : return a + b;                      // Wraps at DATA_WIDTH
      SUB     : return a - b;
      AND_OP  : return a & b;
      OR_OP   : return a | b;
      XOR_OP  : return a ^ b;
      SLL     : return a << (b % DATA_WIDTH);      // Amount modulo width
      SLLI    : return a << (imm % DATA_WIDTH);
      SRL     : return a >> (b % DATA_WIDTH);
      SRLI    : return a >> (imm % DATA_WIDTH);
      default : return sext;                       // LDI and unknown codes
    endcase
  endfunction

  task automatic apply_instr(input instr_t w);
    expect_t e;
    e.rd   = w.rd;
    e.data = model_result(w.func, model_regs[w.rs1], model_regs[w.rs2], w.imm);
    model_regs[w.rd] = e.data;                     // Later reads see it
    exp_q.push_back(e);
  endtask

  task automatic check_result();
    expect_t e;
    test_results++;
    if (exp_q.size() == 0) begin
      $display("Result for r%0d arrived with no instruction outstanding in %s",
               result_rd_i, test_name);
      fail_o++;
      test_errors++;
    end else begin
      e = exp_q.pop_front();
      if (e.rd === result_rd_i && e.data === result_data_i) begin
        pass_o++;
      end else begin
        $display("[FAIL] %s: expected r%0d = %h, actual r%0d = %h",
                 test_name, e.rd, e.data, result_rd_i, result_data_i);
        fail_o++;
        test_errors++;
      end
    end
  endtask

  task automatic open_test(input string name);
    test_name    = name;
    test_results = 0;
    test_errors  = 0;
  endtask

  task automatic close_test(input string name);
    $display("Test %s finished: %0d results, %0d errors", name, test_results, test_errors);
  endtask

  //////////////////////////////
  // Link monitor
  //////////////////////////////
  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_seen = 1'b0;
      req_seen = 1'b0;
      foreach (model_regs[i]) model_regs[i] = '0;   // Matches reset state
      exp_q.delete();
    end else begin
      if (instr_ack_i && !ack_seen) apply_instr(instr_t'(instr_i));  // Word held with req
      if (result_req_i && !req_seen) check_result();
      ack_seen = instr_ack_i;
      req_seen = result_req_i;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_simple_exec.sv ====
// Testbench top with clock, reset, four-phase producer and consumer and timeout
// Stimulus from xorshift with a fixed seed
// Inputs change on the falling edge
// All comparing happens in exec_checker
`timescale 1ns/100ps
`default_nettype none

module tb_simple_exec
  import simple_exec_pkg::*;
();

  localparam int unsigned DATA_WIDTH     = 32;
  localparam int unsigned NUM_INSTR      = 8 + 60 + 60 + 40 + 20;
  localparam int unsigned TIMEOUT_CYCLES = NUM_INSTR * 20 + 100;
  localparam int          POOL_ARITH     = 0;
  localparam int          POOL_SHIFT     = 1;
  localparam int          POOL_MIXED     = 2;

  logic                  clk = 1'b0;
  logic                  reset_i;
  logic                  instr_req_i;
  logic [INSTR_W-1:0]    instr_i;
  logic                  instr_ack_o;
  logic                  result_req_o;
  logic [REG_ADDR_W-1:0] result_rd_o;
  logic [DATA_WIDTH-1:0] result_data_o;
  logic                  result_ack_i;
  int unsigned           pass_count;
  int unsigned           fail_count;
  int unsigned           issued;
  int unsigned           cycle_count;
  int unsigned           ack_lo;        // Ack delay range in cycles
  int unsigned           ack_hi;
  logic [31:0]           stim_state = 32'd45230;
  logic [31:0]           ack_state  = 32'd45230 ^ 32'h5a5a_5a5a;  // Own stream for acks
  logic [REG_ADDR_W-1:0] last_rd;

  always #5 clk = ~clk;   // 10 ns

  simple_exec_top #(.DATA_WIDTH(DATA_WIDTH)) i_simple_exec_top (
    .clk_i         (clk),
    .reset_i       (reset_i),
    .instr_req_i   (instr_req_i),
    .instr_i       (instr_i),
    .instr_ack_o   (instr_ack_o),
    .result_req_o  (result_req_o),
    .result_rd_o   (result_rd_o),
    .result_data_o (result_data_o),
    .result_ack_i  (result_ack_i)
  );

  exec_checker #(.DATA_WIDTH(DATA_WIDTH)) i_exec_checker (
    .clk_i         (clk),
    .reset_i       (reset_i),
    .instr_i       (instr_i),
    .instr_ack_i   (instr_ack_o),
    .result_req_i  (result_req_o),
    .result_rd_i   (result_rd_o),
    .result_data_i (result_data_o),
    .pass_o        (pass_count),
    .fail_o        (fail_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////
  // Producer side
  //////////////////////////////
  task automatic send_instr(input instr_t w);
    @(negedge clk);
    instr_i     = w;                       // Held until the next request
    instr_req_i = 1'b1;
    @(negedge clk);
    while (!instr_ack_o) @(negedge clk);   // Stalls under back-pressure
    instr_req_i = 1'b0;
    while (instr_ack_o) @(negedge clk);
    issued++;
  endtask

  task automatic issue_random(input int pool, input int count, input bit chain);
    instr_t w;
    logic [31:0] r;
    for (int n = 0; n < count; n++) begin
      stim_state = xorshift32(stim_state);
      r = stim_state;
      w = '0;
      case (pool)
        POOL_ARITH : w.func = 4'(r[31:28] % 5);          // ADD to XOR_OP
        POOL_SHIFT : w.func = 4'(SLL) + 4'(r[31:28] % 4); // Shift codes only
        default    : w.func = 4'(r[31:28] % 10);
      endcase
      w.rd  = r[15:13];
      w.rs1 = chain ? last_rd : r[12:10];  // Read what was just written
      w.rs2 = r[9:7];
      w.imm = r[5:0];                      // Up to 63 so SLLI and SRLI amounts wrap too
      send_instr(w);
      last_rd = w.rd;
    end
  endtask

  task automatic load_regs();
    instr_t w;
    for (int n = 0; n < 8; n++) begin
      stim_state = xorshift32(stim_state);
      w      = '0;
      w.func = LDI;
      w.rd   = REG_ADDR_W'(n);
      w.imm  = stim_state[5:0];
      send_instr(w);
    end
  endtask

  task automatic start_test(input string name, input int unsigned lo, input int unsigned hi);
    ack_lo = lo;
    ack_hi = hi;
    i_exec_checker.open_test(name);
  endtask

  // Wait until every issued result has been checked
  task automatic finish_test(input string name);
    while (pass_count + fail_count < issued) @(negedge clk);
    i_exec_checker.close_test(name);
  endtask

  //////////////////////////////
  // Consumer side
  //////////////////////////////
  always begin
    @(negedge clk);
    if (result_req_o === 1'b1 && !result_ack_i) begin
      ack_state = xorshift32(ack_state);
      repeat (ack_lo + ack_state % (ack_hi - ack_lo + 1)) @(negedge clk);
      result_ack_i = 1'b1;
    end else if (result_req_o === 1'b0 && result_ack_i) begin
      result_ack_i = 1'b0;                 // Phase 4
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    reset_i      = 1'b1;
    instr_req_i  = 1'b0;
    instr_i      = '0;
    result_ack_i = 1'b0;
    ack_lo       = 0;
    ack_hi       = 3;
    last_rd      = '0;
    repeat (5) @(negedge clk);
    reset_i = 1'b0;

    start_test("load_regs", 0, 3);
    load_regs();
    finish_test("load_regs");
    start_test("arith_logic", 0, 3);
    issue_random(POOL_ARITH, 60, 1'b0);
    finish_test("arith_logic");
    start_test("shifts", 0, 3);            // Only low 5 bits of amount count
    issue_random(POOL_SHIFT, 60, 1'b0);
    finish_test("shifts");
    start_test("back_to_back", 0, 0);
    issue_random(POOL_MIXED, 40, 1'b1);
    finish_test("back_to_back");
    start_test("backpressure", 10, 20);
    issue_random(POOL_MIXED, 20, 1'b0);
    finish_test("backpressure");

    $display("Totals: %0d checks passed, %0d checks failed, %0d instructions issued",
             pass_count, fail_count, issued);
    if (fail_count == 0 && pass_count == issued) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== simple_exec.f ====
src/simple_exec_pkg.sv
src/instr_intake.sv
src/reg_file.sv
src/alu_shift.sv
src/alu_core.sv
src/result_sender.sv
src/simple_exec_top.sv
dv/exec_checker.sv
dv/tb_simple_exec.sv

// ==== src/alu_core.sv ====
// Combinational ALU for add, sub, bitwise ops, immediate load and shifts
// Add and sub wrap at DATA_WIDTH and set no flags
// Immediate is sign-extended for LDI only
`timescale 1ns/100ps
`default_nettype none

module alu_core
  import simple_exec_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire decoded_t              dec_i,
  input  wire logic [DATA_WIDTH-1:0] rs1_data_i,
  input  wire logic [DATA_WIDTH-1:0] rs2_data_i,
  output logic      [DATA_WIDTH-1:0] result_o
);

  logic [DATA_WIDTH-1:0] imm_sext;
  logic [DATA_WIDTH-1:0] shift_result;

  assign imm_sext = {{(DATA_WIDTH - IMM_W){dec_i.imm[IMM_W-1]}}, dec_i.imm};

  //////////////////////////////
  // Shift block
  //////////////////////////////
  alu_shift #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_alu_shift (
    .rs1_data_i (rs1_data_i),
    .rs2_data_i (rs2_data_i),
    .func_i     (dec_i.func),
    .imm_i      (dec_i.imm),
    .result_o   (shift_result)
  );

  //////////////////////////////
  // Result select
  //////////////////////////////
  always_comb begin
    case (dec_i.func)
      ADD     : result_o = rs1_data_i + rs2_data_i;   // Wraps
      SUB     : result_o = rs1_data_i - rs2_data_i;
      AND_OP  : result_o = rs1_data_i & rs2_data_i;
      OR_OP   : result_o = rs1_data_i | rs2_data_i;
      XOR_OP  : result_o = rs1_data_i ^ rs2_data_i;
      SLL,
      SLLI,
      SRL,
      SRLI    : result_o = shift_result;
      LDI     : result_o = imm_sext;
      default : result_o = imm_sext;                  // Intake never passes other codes
    endcase
  end

endmodule

`default_nettype wire

// ==== src/alu_shift.sv ====
// Logical shifter for SLL, SLLI, SRL and SRLI
// Only the low log2(DATA_WIDTH) bits of the amount count
// DATA_WIDTH must be a power of two
`timescale 1ns/100ps
`default_nettype none

module alu_shift
  import simple_exec_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire logic [DATA_WIDTH-1:0] rs1_data_i,   // Value to shift
  input  wire logic [DATA_WIDTH-1:0] rs2_data_i,   // Amount for R forms
  input  wire func_t                 func_i,
  input  wire logic [IMM_W-1:0]      imm_i,        // Amount for I forms
  output logic      [DATA_WIDTH-1:0] result_o
);

  localparam int unsigned SHAMT_W = $clog2(DATA_WIDTH);

  logic [DATA_WIDTH-1:0] imm_wide;     // Zero-extended so any width slices cleanly
  logic [SHAMT_W-1:0]    shamt;
  logic                  shift_right;

  assign imm_wide = DATA_WIDTH'(imm_i);

  always_comb begin
    shift_right = 1'b0;
    shamt       = rs2_data_i[SHAMT_W-1:0];   // R forms by default
    case (func_i)
      SLLI    : shamt = imm_wide[SHAMT_W-1:0];
      SRL     : shift_right = 1'b1;
      SRLI    : begin
        shift_right = 1'b1;
        shamt       = imm_wide[SHAMT_W-1:0];
      end
      default : ;                              // SLL, other codes ignore the result
    endcase
  end

  assign result_o = shift_right ? (rs1_data_i >> shamt) : (rs1_data_i << shamt);

endmodule

`default_nettype wire

// ==== src/instr_intake.sv ====
// Four-phase receiver for instruction words with a one-entry holding register
// instr_i must stay stable while instr_req_i is high
// No ack is given while the holding register is full and not being taken
`timescale 1ns/100ps
`default_nettype none

module instr_intake
  import simple_exec_pkg::*;
(
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  input  wire logic               instr_req_i,
  input  wire logic [INSTR_W-1:0] instr_i,
  output logic                    instr_ack_o,
  output logic                    dec_valid_o,
  output decoded_t                dec_o,
  input  wire logic               dec_take_i
);

  instr_t   instr;       // Field view of the raw word
  decoded_t dec_next;
  logic     accept;      // Handshake phase 1 completes this edge
  logic     ack_q;
  logic     valid_q;
  decoded_t dec_q;

  //////////////////////////////
  // Decode
  //////////////////////////////
  assign instr = instr_t'(instr_i);

  always_comb begin
    dec_next.rd  = instr.rd;
    dec_next.rs1 = instr.rs1;
    dec_next.rs2 = instr.rs2;
    dec_next.imm = instr.imm;
    if (instr.func <= FUNC_W'(LDI)) begin
      dec_next.func = func_t'(instr.func);
    end else begin
      dec_next.func = LDI;                   // Undefined codes fall back to load
    end
  end

  // Ack low, request up, slot free or emptying now
  assign accept = !ack_q && instr_req_i && (!valid_q || dec_take_i);

  //////////////////////////////
  // Handshake and holding reg
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (accept) begin
        ack_q   <= 1'b1;                     // Ack and valid rise together
        valid_q <= 1'b1;
      end else begin
        if (ack_q && !instr_req_i) ack_q <= 1'b0;  // Phase 3 seen, release
        if (dec_take_i) valid_q <= 1'b0;
      end
    end
  end

  // Payload, no reset
  always_ff @(posedge clk_i) begin
    if (accept) dec_q <= dec_next;
  end

  assign instr_ack_o = ack_q;
  assign dec_valid_o = valid_q;
  assign dec_o       = dec_q;

  // Full and not drained means no new ack next cycle
  a_no_ack_when_full : assert property (@(posedge clk_i) disable iff (reset_i)
    (!instr_ack_o && dec_valid_o && !dec_take_i) |=> !instr_ack_o);

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// Eight-entry register file, two async reads, one sync write
// A write is visible to reads from the next cycle on, no bypass
// All registers clear on reset
`timescale 1ns/100ps
`default_nettype none

module reg_file
  import simple_exec_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic [REG_ADDR_W-1:0] rs1_addr_i,
  input  wire logic [REG_ADDR_W-1:0] rs2_addr_i,
  output logic      [DATA_WIDTH-1:0] rs1_data_o,
  output logic      [DATA_WIDTH-1:0] rs2_data_o,
  input  wire logic                  we_i,
  input  wire logic [REG_ADDR_W-1:0] wr_addr_i,
  input  wire logic [DATA_WIDTH-1:0] wr_data_i
);

  localparam int unsigned NUM_REGS = 2 ** REG_ADDR_W;

  logic [DATA_WIDTH-1:0] regs_q [NUM_REGS];

  // Write port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[wr_addr_i] <= wr_data_i;   // r0 writable like the rest
    end
  end

  // Read ports, combinational
  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

`default_nettype wire

// ==== src/result_sender.sv ====
// Captures an ALU result, writes it back, offers it on a four-phase link
// Capture only when req and ack are both low
// rd and data hold stable for the whole request phase
`timescale 1ns/100ps
`default_nettype none

module result_sender
  import simple_exec_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  dec_valid_i,
  input  wire logic [REG_ADDR_W-1:0] dec_rd_i,
  input  wire logic [DATA_WIDTH-1:0] alu_result_i,
  output logic                       dec_take_o,
  output logic                       we_o,
  output logic      [REG_ADDR_W-1:0] wr_addr_o,
  output logic      [DATA_WIDTH-1:0] wr_data_o,
  output logic                       result_req_o,
  output logic      [REG_ADDR_W-1:0] result_rd_o,
  output logic      [DATA_WIDTH-1:0] result_data_o,
  input  wire logic                  result_ack_i
);

  logic                  capture;   // Idle link and a word waiting
  logic                  req_q;
  logic [REG_ADDR_W-1:0] rd_q;
  logic [DATA_WIDTH-1:0] data_q;

  assign capture = dec_valid_i && !req_q && !result_ack_i;

  // Take, writeback and capture share one edge
  assign dec_take_o = capture;
  assign we_o       = capture;
  assign wr_addr_o  = dec_rd_i;
  assign wr_data_o  = alu_result_i;

  //////////////////////////////
  // Output handshake
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q <= 1'b0;
    end else if (capture) begin
      req_q <= 1'b1;
    end else if (req_q && result_ack_i) begin
      req_q <= 1'b0;                       // Drop the cycle after ack
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      rd_q   <= dec_rd_i;
      data_q <= alu_result_i;
    end
  end

  assign result_req_o  = req_q;
  assign result_rd_o   = rd_q;
  assign result_data_o = data_q;

  // Payload frozen through the request phase
  a_payload_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    (result_req_o ##1 result_req_o) |-> ($stable(result_rd_o) && $stable(result_data_o)));

  // One writeback per handshake
  a_we_single : assert property (@(posedge clk_i) disable iff (reset_i)
    we_o |=> !we_o);

endmodule

`default_nettype wire

// ==== src/simple_exec_pkg.sv ====
// Shared types for the execute subsystem
// DATA_WIDTH is not here; it is a module parameter set at the top level
// Func codes above LDI are not defined and decode as LDI
`default_nettype none

package simple_exec_pkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////
  localparam int unsigned FUNC_W     = 4;
  localparam int unsigned REG_ADDR_W = 3;   // Eight registers, r0 is ordinary
  localparam int unsigned IMM_W      = 6;
  localparam int unsigned INSTR_W    = 20;

  // Opcode space, 4 bits
  typedef enum logic [FUNC_W-1:0] {
    ADD    = 4'd0,
    SUB    = 4'd1,
    AND_OP = 4'd2,
    OR_OP  = 4'd3,
    XOR_OP = 4'd4,
    SLL    = 4'd5,
    SLLI   = 4'd6,
    SRL    = 4'd7,
    SRLI   = 4'd8,
    LDI    = 4'd9     // Highest legal code
  } func_t;

  // Raw instruction word, MSB first
  typedef struct packed {
    logic [FUNC_W-1:0]     func;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  spare;   // Ignored by decode
    logic [IMM_W-1:0]      imm;
  } instr_t;

  // Decoded word, 19 bits, intake to core and sender
  typedef struct packed {
    func_t                 func;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [IMM_W-1:0]      imm;
  } decoded_t;

endpackage

`default_nettype wire

// ==== src/simple_exec_top.sv ====
// Execute subsystem top: intake, register file, ALU, result sender
// DATA_WIDTH must be a power of two, at least 8
// Latency req in to req out is 2 cycles with an idle output link
`timescale 1ns/100ps
`default_nettype none

module simple_exec_top
  import simple_exec_pkg::*;
#(
  parameter int unsigned DATA_WIDTH = 32
) (
  input  wire logic                  clk_i,
  input  wire logic                  reset_i,
  input  wire logic                  instr_req_i,
  input  wire logic [INSTR_W-1:0]    instr_i,
  output logic                       instr_ack_o,
  output logic                       result_req_o,
  output logic      [REG_ADDR_W-1:0] result_rd_o,
  output logic      [DATA_WIDTH-1:0] result_data_o,
  input  wire logic                  result_ack_i
);

  //////////////////////////////
  // Internal nets
  //////////////////////////////
  decoded_t              dec;
  logic                  dec_valid;
  logic                  dec_take;
  logic [DATA_WIDTH-1:0] rs1_data;
  logic [DATA_WIDTH-1:0] rs2_data;
  logic [DATA_WIDTH-1:0] alu_result;
  logic                  we;          // Writeback strobe
  logic [REG_ADDR_W-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;

  instr_intake i_instr_intake (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .instr_ack_o (instr_ack_o),
    .dec_valid_o (dec_valid),
    .dec_o       (dec),
    .dec_take_i  (dec_take)
  );

  reg_file #(.DATA_WIDTH(DATA_WIDTH)) i_reg_file (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rs1_addr_i (dec.rs1),
    .rs2_addr_i (dec.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (we),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data)
  );

  alu_core #(.DATA_WIDTH(DATA_WIDTH)) i_alu_core (
    .dec_i      (dec),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .result_o   (alu_result)
  );

  result_sender #(.DATA_WIDTH(DATA_WIDTH)) i_result_sender (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .dec_valid_i   (dec_valid),
    .dec_rd_i      (dec.rd),
    .alu_result_i  (alu_result),
    .dec_take_o    (dec_take),
    .we_o          (we),
    .wr_addr_o     (wr_addr),
    .wr_data_o     (wr_data),
    .result_req_o  (result_req_o),
    .result_rd_o   (result_rd_o),
    .result_data_o (result_data_o),
    .result_ack_i  (result_ack_i)
  );

endmodule

`default_nettype wire
